// File: Bender.yml
package:
  name: stream_buffer

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - logic/stream_pkg.sv
      - logic/sdp_ram.sv
      - logic/sync_fifo.sv
      - logic/ingress_tagger.sv
      - logic/egress_sender.sv
      - logic/stream_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - verif/stream_properties.sv
      - verif/stream_tb.sv

// File: filelist.f
+incdir+include
logic/stream_pkg.sv
logic/sdp_ram.sv
logic/sync_fifo.sv
logic/ingress_tagger.sv
logic/egress_sender.sv
logic/stream_top.sv
verif/stream_properties.sv
verif/stream_tb.sv

// File: include/stream_settings.svh
// size settings for the tagged word stream: data width, sequence width, fifo depth
`ifndef STREAM_SETTINGS_SVH
`define STREAM_SETTINGS_SVH

// ========================================
// payload
// ========================================

// width of one data word on the ingress port
`define STREAM_DATA_W 16

// sequence tag width, tags wrap modulo 2**STREAM_SEQ_W
`define STREAM_SEQ_W 6

// ========================================
// buffer
// ========================================

// fifo entries, need not be a power of two
// the output register of the egress side holds one more word
`define STREAM_FIFO_DEPTH 8

`endif

// File: logic/egress_sender.sv
// egress side: pops fifo entries, registers them and drives the four-phase sender
module egress_sender (
  input  logic               clk,
  input  logic               rst_n,
  // fifo read side
  input  logic               empty_i,
  output logic               pop_o,
  input  stream_pkg::entry_t rd_entry_i,
  // four-phase egress port
  output logic               out_req_o,
  output stream_pkg::entry_t out_entry_o,
  input  logic               out_ack_i
);

  // ========================================
  // handshake fsm
  // ========================================

  // load covers the ram read latency
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_LOAD,
    ST_PRESENT,
    ST_RELEASE
  } state_e;

  state_e state_q;
  state_e state_d;

  // one pop per entry, only between handshakes
  assign pop_o = (state_q == ST_IDLE) && !empty_i;

  // req is a pure state decode, no glitches
  assign out_req_o = (state_q == ST_PRESENT);

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE:    if (pop_o)      state_d = ST_LOAD;
      ST_LOAD:    state_d = ST_PRESENT;
      ST_PRESENT: if (out_ack_i)  state_d = ST_RELEASE;
      // wait for the far side to drop ack
      ST_RELEASE: if (!out_ack_i) state_d = ST_IDLE;
      default:    state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // ========================================
  // output register
  // ========================================

  // read data valid during load, held until the next load
  always_ff @(posedge clk) begin
    if (state_q == ST_LOAD) begin
      out_entry_o <= rd_entry_i;
    end
  end

endmodule

// File: logic/ingress_tagger.sv
// four-phase ingress receiver, tags each accepted word with a sequence number
module ingress_tagger (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               flush_i,
  // four-phase ingress port
  input  logic               in_req_i,
  input  stream_pkg::data_t  in_data_i,
  output logic               in_ack_o,
  // fifo write side
  input  logic               full_i,
  output logic               push_o,
  output stream_pkg::entry_t push_entry_o
);

  // idle waits for req, ack waits for req to drop
  typedef enum logic {
    ST_IDLE,
    ST_ACK
  } state_e;

  state_e           state_q;
  state_e           state_d;
  stream_pkg::seq_t seq_q;
  logic             accept;

  // take the word once per request, only with room in the fifo
  assign accept = (state_q == ST_IDLE) && in_req_i && !full_i;
  assign push_o = accept;

  // tag with the current count
  assign push_entry_o = '{seq: seq_q, data: in_data_i};

  // ack straight from the state register
  assign in_ack_o = (state_q == ST_ACK);

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: if (accept)    state_d = ST_ACK;
      ST_ACK:  if (!in_req_i) state_d = ST_IDLE;
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // sequence counter, wraps naturally at 2**width
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      seq_q <= '0;
    end else if (flush_i) begin
      seq_q <= '0;
    end else if (accept) begin
      seq_q <= seq_q + 1'b1;
    end
  end

endmodule

// File: logic/sdp_ram.sv
// simple dual-port ram: one write port, one registered read port, generic word type
module sdp_ram #(
  parameter type         word_t = logic,
  parameter int unsigned DEPTH  = 8
) (
  input  logic                                 clk,
  // write port
  input  logic                                 we_i,
  input  logic [((DEPTH > 1) ? $clog2(DEPTH) : 1)-1:0] waddr_i,
  input  word_t                                wdata_i,
  // read port, data one cycle after the address
  input  logic [((DEPTH > 1) ? $clog2(DEPTH) : 1)-1:0] raddr_i,
  output word_t                                rdata_o
);

  // storage array
  word_t mem_q [DEPTH];

  // write side
  always_ff @(posedge clk) begin
    if (we_i) begin
      mem_q[waddr_i] <= wdata_i;
    end
  end

  // read side, always enabled
  // caller keeps raddr_i away from the address being written
  always_ff @(posedge clk) begin
    rdata_o <= mem_q[raddr_i];
  end

endmodule

// File: logic/stream_pkg.sv
// shared types of the stream buffer: data word, sequence tag, fifo entry, fill level
`include "stream_settings.svh"

package stream_pkg;

  // raw payload word as seen on in_data_i
  typedef logic [`STREAM_DATA_W-1:0] data_t;

  // sequence tag, counts accepted words since the last flush
  typedef logic [`STREAM_SEQ_W-1:0] seq_t;

  // ========================================
  // fifo payload and egress output
  // ========================================

  // tag in the upper bits, data in the lower bits
  typedef struct packed {
    seq_t  seq;
    data_t data;
  } entry_t;

  // occupancy from 0 up to depth inclusive
  typedef logic [$clog2(`STREAM_FIFO_DEPTH + 1)-1:0] level_t;

endpackage

// File: logic/stream_top.sv
// top level of the buffered stream: ingress tagger, fifo, egress sender
`include "stream_settings.svh"

module stream_top (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               flush_i,
  // ingress four-phase port
  input  logic               in_req_i,
  input  stream_pkg::data_t  in_data_i,
  output logic               in_ack_o,
  // egress four-phase port
  output logic               out_req_o,
  output stream_pkg::entry_t out_entry_o,
  input  logic               out_ack_i,
  // buffer status
  output stream_pkg::level_t level_o,
  output logic               full_o
);

  // ingress to fifo
  logic               push;
  stream_pkg::entry_t push_entry;
  logic               fifo_full;

  // fifo to egress
  logic               pop;
  logic               fifo_empty;
  stream_pkg::entry_t rd_entry;

  assign full_o = fifo_full;

  ingress_tagger u_ingress (
    .clk          (clk),
    .rst_n        (rst_n),
    .flush_i      (flush_i),
    .in_req_i     (in_req_i),
    .in_data_i    (in_data_i),
    .in_ack_o     (in_ack_o),
    .full_i       (fifo_full),
    .push_o       (push),
    .push_entry_o (push_entry)
  );

  // egress is kept out of the flush path
  sync_fifo #(
    .entry_type (stream_pkg::entry_t),
    .DEPTH      (`STREAM_FIFO_DEPTH)
  ) u_fifo (
    .clk     (clk),
    .rst_n   (rst_n),
    .flush_i (flush_i),
    .push_i  (push),
    .pop_i   (pop),
    .data_i  (push_entry),
    .data_o  (rd_entry),
    .empty_o (fifo_empty),
    .full_o  (fifo_full),
    .level_o (level_o)
  );

  egress_sender u_egress (
    .clk         (clk),
    .rst_n       (rst_n),
    .empty_i     (fifo_empty),
    .pop_o       (pop),
    .rd_entry_i  (rd_entry),
    .out_req_o   (out_req_o),
    .out_entry_o (out_entry_o),
    .out_ack_i   (out_ack_i)
  );

endmodule

// File: logic/sync_fifo.sv
// synchronous fifo with wrap-around pointers, occupancy counter, flush, full and level
`include "stream_settings.svh"

module sync_fifo #(
  parameter type         entry_type = stream_pkg::entry_t,
  parameter int unsigned DEPTH      = `STREAM_FIFO_DEPTH
) (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               flush_i,
  input  logic               push_i,
  input  logic               pop_i,
  input  entry_type          data_i,
  output entry_type          data_o,
  output logic               empty_o,
  output logic               full_o,
  output stream_pkg::level_t level_o
);

  // ========================================
  // sizes
  // ========================================

  localparam int unsigned AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  typedef logic [AW-1:0] ptr_t;

  // last valid slot, pointers wrap here
  localparam ptr_t LAST_PTR = ptr_t'(DEPTH - 1);
  // count value that means full
  localparam stream_pkg::level_t FULL_LVL = stream_pkg::level_t'(DEPTH);

  // pointers and count
  ptr_t               wr_ptr_q;
  ptr_t               wr_ptr_d;
  ptr_t               rd_ptr_q;
  ptr_t               rd_ptr_d;
  stream_pkg::level_t count_q;
  stream_pkg::level_t count_d;

  // qualified requests
  logic ram_we;
  logic do_pop;

  // wrap at DEPTH, also for odd depths
  function automatic ptr_t ptr_inc(input ptr_t ptr);
    if (ptr == LAST_PTR) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // ========================================
  // status
  // ========================================

  assign full_o  = (count_q == FULL_LVL);
  assign empty_o = (count_q == '0);
  assign level_o = count_q;

  // push dropped when full or flushing, pop dropped when empty
  assign ram_we = push_i && !full_o && !flush_i;
  assign do_pop = pop_i && !empty_o;

  // ========================================
  // pointer and count update
  // ========================================

  always_comb begin
    wr_ptr_d = wr_ptr_q;
    rd_ptr_d = rd_ptr_q;
    count_d  = count_q;
    if (ram_we) begin
      wr_ptr_d = ptr_inc(wr_ptr_q);
    end
    if (do_pop) begin
      rd_ptr_d = ptr_inc(rd_ptr_q);
    end
    // push and pop together keep the count
    case ({ram_we, do_pop})
      2'b10:   count_d = count_q + 1'b1;
      2'b01:   count_d = count_q - 1'b1;
      default: count_d = count_q;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin
      // flush wins over push and pop
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      wr_ptr_q <= wr_ptr_d;
      rd_ptr_q <= rd_ptr_d;
      count_q  <= count_d;
    end
  end

  // storage, read port addressed by the head so data follows a pop by one cycle
  sdp_ram #(
    .word_t (entry_type),
    .DEPTH  (DEPTH)
  ) u_ram (
    .clk     (clk),
    .we_i    (ram_we),
    .waddr_i (wr_ptr_q),
    .wdata_i (data_i),
    .raddr_i (rd_ptr_q),
    .rdata_o (data_o)
  );

endmodule

// File: verif/stream_properties.sv
// handshake and fifo assertions, bound into sync_fifo and egress_sender
`include "stream_settings.svh"

module stream_properties #(
  parameter bit          CHECK_FIFO = 1'b1,
  parameter int unsigned PTR_W      = (`STREAM_FIFO_DEPTH > 1) ? $clog2(`STREAM_FIFO_DEPTH) : 1
) (
  input logic               clk,
  input logic               rst_n,
  // fifo side
  input logic               flush,
  input logic [PTR_W-1:0]   wr_ptr,
  input logic               full,
  input stream_pkg::level_t level,
  // egress side
  input logic               out_req,
  input stream_pkg::entry_t out_entry,
  input logic               out_ack
);

  if (CHECK_FIFO) begin : g_fifo
    // write pointer frozen while full, a write would overwrite the head
    assert property (@(posedge clk) disable iff (!rst_n) (full && !flush) |=> $stable(wr_ptr))
      else $error("ram written while fifo full");
    assert property (@(posedge clk) disable iff (!rst_n) level <= `STREAM_FIFO_DEPTH)
      else $error("fifo level above depth");
  end else begin : g_egress
    // entry held for the whole request phase
    assert property (@(posedge clk) disable iff (!rst_n)
                     (out_req && $past(out_req)) |-> (out_entry == $past(out_entry)))
      else $error("out_entry changed while out_req high");
    assert property (@(posedge clk) disable iff (!rst_n) $rose(out_req) |-> !out_ack)
      else $error("out_req rose while out_ack high");
  end

endmodule

bind sync_fifo stream_properties #(.CHECK_FIFO(1'b1)) u_fifo_props (
  .clk       (clk),
  .rst_n     (rst_n),
  .flush     (flush_i),
  .wr_ptr    (wr_ptr_q),
  .full      (full_o),
  .level     (level_o),
  .out_req   (1'b0),
  .out_entry ('0),
  .out_ack   (1'b0)
);

bind egress_sender stream_properties #(.CHECK_FIFO(1'b0)) u_egress_props (
  .clk       (clk),
  .rst_n     (rst_n),
  .flush     (1'b0),
  .wr_ptr    ('0),
  .full      (1'b0),
  .level     ('0),
  .out_req   (out_req_o),
  .out_entry (out_entry_o),
  .out_ack   (out_ack_i)
);

// File: verif/stream_tb.sv
// testbench for the tagged word stream: clock, reset, lfsr stimulus, queue model, checks, watchdog
`include "stream_settings.svh"

module stream_tb;

  localparam int unsigned NUM_WORDS = 200;
  localparam int unsigned DEPTH     = `STREAM_FIFO_DEPTH;

  logic               clk;
  logic               rst_n;
  logic               flush_i;
  logic               in_req_i;
  stream_pkg::data_t  in_data_i;
  logic               in_ack_o;
  logic               out_req_o;
  stream_pkg::entry_t out_entry_o;
  logic               out_ack_i;
  stream_pkg::level_t level_o;
  logic               full_o;

  // model state
  stream_pkg::entry_t model_q[$];
  stream_pkg::entry_t pending;
  logic               pending_valid;
  logic               holding;
  int unsigned        seq_cnt;
  int unsigned        delivered;
  logic               saw_full;
  logic               sender_done;
  logic [31:0]        lfsr_q;

  stream_top uut (
    .clk         (clk),
    .rst_n       (rst_n),
    .flush_i     (flush_i),
    .in_req_i    (in_req_i),
    .in_data_i   (in_data_i),
    .in_ack_o    (in_ack_o),
    .out_req_o   (out_req_o),
    .out_entry_o (out_entry_o),
    .out_ack_i   (out_ack_i),
    .level_o     (level_o),
    .full_o      (full_o)
  );

  // ========================================
  // helpers
  // ========================================

  // galois lfsr, taps for x^32 x^30 x^26 x^25
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'ha300_0000;
    end
    return s >> 1;
  endfunction

  // one lfsr step per bit taken
  task automatic draw_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      val    = {val[30:0], lfsr_q[0]};
    end
  endtask

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("Test FAILED");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_entry(input stream_pkg::entry_t got, input stream_pkg::entry_t exp);
    if (got !== exp) begin
      stop_on_error($sformatf("mismatch at %0t: got seq %0d data %h, expected seq %0d data %h",
                              $time, got.seq, got.data, exp.seq, exp.data));
    end
  endtask

  task automatic check_level(input stream_pkg::level_t got, input logic full);
    if (got > DEPTH || full !== (got == DEPTH)) begin
      stop_on_error($sformatf("mismatch at %0t: level_o %0d with full_o %b, depth %0d",
                              $time, got, full, DEPTH));
    end
  endtask

  // ========================================
  // clock, reset, watchdog
  // ========================================

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  initial begin
    #(NUM_WORDS * 40 * 100);
    $display("watchdog expired before all words were delivered");
    $display("Test FAILED");
    $fatal(1, "watchdog timeout");
  end

  // ========================================
  // monitor and model
  // ========================================

  always @(negedge clk) begin
    logic prev_in_ack;
    logic prev_out_req;
    logic prev_out_ack;
    stream_pkg::entry_t exp;
    if (rst_n) begin
      check_level(level_o, full_o);
      if (full_o) saw_full = 1'b1;
      // ingress word accepted on ack rise
      if (in_ack_o && !prev_in_ack) begin
        if (!in_req_i) stop_on_error("in_ack_o rose without in_req_i");
        exp.seq  = stream_pkg::seq_t'(seq_cnt % (1 << `STREAM_SEQ_W));
        exp.data = in_data_i;
        model_q.push_back(exp);
        seq_cnt++;
      end
      if (!in_ack_o && prev_in_ack && in_req_i) begin
        stop_on_error("in_ack_o fell while in_req_i was still high");
      end
      // egress presentation
      if (out_req_o && !prev_out_req) begin
        if (out_ack_i) stop_on_error("out_req_o rose while out_ack_i was high");
        if (pending_valid && out_entry_o === pending) begin
          pending_valid = 1'b0;
        end else begin
          pending_valid = 1'b0;
          if (model_q.size() == 0) stop_on_error("out_req_o rose with nothing expected");
          check_entry(out_entry_o, model_q.pop_front());
        end
        holding = 1'b1;
      end
      if (out_ack_i && !prev_out_ack) begin
        holding = 1'b0;
        delivered++;
      end
      // fifo plus output register bound
      if (model_q.size() + holding > DEPTH + 1) begin
        stop_on_error("more words accepted than the buffer can hold");
      end
      // flush keeps at most the word egress may have popped
      if (flush_i) begin
        pending_valid = (model_q.size() != 0);
        if (pending_valid) pending = model_q[0];
        model_q.delete();
        seq_cnt = 0;
      end
    end
    prev_in_ack  = in_ack_o;
    prev_out_req = out_req_o;
    prev_out_ack = out_ack_i;
  end

  // ========================================
  // stimulus
  // ========================================

  initial begin
    logic [31:0] r;
    lfsr_q        = 32'h27a2_fa49;
    rst_n         = 1'b0;
    flush_i       = 1'b0;
    in_req_i      = 1'b0;
    in_data_i     = '0;
    out_ack_i     = 1'b0;
    pending_valid = 1'b0;
    pending       = '0;
    holding       = 1'b0;
    seq_cnt       = 0;
    delivered     = 0;
    saw_full      = 1'b0;
    sender_done   = 1'b0;
    repeat (10) @(posedge clk);
    #10 rst_n = 1'b1;
    @(negedge clk);
    if (in_ack_o || out_req_o) stop_on_error("handshake outputs not low after reset");
    check_level(level_o, full_o);
    if (level_o != 0) stop_on_error("fifo not empty after reset");
    fork
      // ingress sender
      begin
        for (int i = 0; i < NUM_WORDS; i++) begin
          draw_bits(3, r);
          repeat (r) @(posedge clk);
          // flush while the ingress side is idle
          if (i == 60 || i == 130 || i == 170) begin
            @(posedge clk);
            #10 flush_i = 1'b1;
            @(posedge clk);
            #10 flush_i = 1'b0;
          end
          @(posedge clk);
          draw_bits(16, r);
          #10;
          in_data_i = r[15:0];
          in_req_i  = 1'b1;
          do @(negedge clk); while (!in_ack_o);
          @(posedge clk);
          #10 in_req_i = 1'b0;
          do @(negedge clk); while (in_ack_o);
        end
        sender_done = 1'b1;
      end
      // egress receiver, one long stall to fill the buffer
      begin
        forever begin
          do @(negedge clk); while (!out_req_o);
          if (delivered == 50) begin
            repeat (80) @(posedge clk);
          end else begin
            draw_bits(2, r);
            repeat (r) @(posedge clk);
          end
          @(posedge clk);
          #10 out_ack_i = 1'b1;
          do @(negedge clk); while (out_req_o);
          @(posedge clk);
          #10 out_ack_i = 1'b0;
        end
      end
    join_none
    // drain
    do @(negedge clk); while (!sender_done || model_q.size() != 0 || out_req_o || out_ack_i);
    repeat (10) @(negedge clk);
    if (out_req_o || model_q.size() != 0) begin
      stop_on_error("words left over after drain");
    end else if (!saw_full) begin
      stop_on_error("fifo never filled during the egress stall");
    end else begin
      $display("Test OK");
    end
    $finish;
  end

endmodule
